// ==== src/z80_alu_pkg.sv ====
`default_nettype none

package z80_alu_pkg;

	// one data byte
	typedef logic [7:0] byte_t;

	// flag byte, S Z 0 H 0 PV N C from bit 7 down
	typedef logic [7:0] flags_t;

	// bit positions inside flags_t
	localparam int FLAG_C  = 0;
	localparam int FLAG_N  = 1;
	localparam int FLAG_PV = 2;
	localparam int FLAG_H  = 4;
	localparam int FLAG_Z  = 6;
	localparam int FLAG_S  = 7;

	// opcode encoding of sel, 14 is not named and decodes as nop
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_sbc = 4'd2,
		op_adc = 4'd3,
		op_and = 4'd4,
		op_or  = 4'd5,
		op_xor = 4'd6,
		op_cp  = 4'd7,
		op_inc = 4'd8,
		op_dec = 4'd9,
		op_cpl = 4'd10,
		op_neg = 4'd11,
		op_ccf = 4'd12,
		op_scf = 4'd13,
		op_nop = 4'd15
	} alu_op_e;

endpackage

`default_nettype wire

// ==== src/alu_arith.sv ====
`default_nettype none

module alu_arith (
	input  var z80_alu_pkg::alu_op_e op,
	input  var z80_alu_pkg::byte_t   acc,
	input  var z80_alu_pkg::byte_t   data_bus,
	input  wire logic                carry_in,
	output z80_alu_pkg::byte_t       arith_result,
	output logic                     carry_out,
	output logic                     half_out,
	output logic                     ovf_out
);

	// adder operands and carry in
	z80_alu_pkg::byte_t x;
	z80_alu_pkg::byte_t y;
	logic cin;
	// set for ops whose carries are borrows
	logic sub_mode;
	logic [8:0] sum9;
	logic [4:0] nib5;

	//////////////////////////////////////////////////////////////////////
	// operand selection
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		x        = acc;
		y        = data_bus;
		cin      = 1'b0;
		sub_mode = 1'b0;
		case (op)
			z80_alu_pkg::op_adc:
				cin = carry_in;
			// a + ~b + 1
			z80_alu_pkg::op_sub, z80_alu_pkg::op_cp:
			begin
				y        = ~data_bus;
				cin      = 1'b1;
				sub_mode = 1'b1;
			end
			// extra borrow taken off the carry in
			z80_alu_pkg::op_sbc:
			begin
				y        = ~data_bus;
				cin      = ~carry_in;
				sub_mode = 1'b1;
			end
			// inc and dec work on the bus operand
			z80_alu_pkg::op_inc:
			begin
				x   = data_bus;
				y   = 8'h00;
				cin = 1'b1;
			end
			z80_alu_pkg::op_dec:
			begin
				x        = data_bus;
				y        = 8'hff;
				sub_mode = 1'b1;
			end
			// 0 - a as 0 + ~a + 1
			z80_alu_pkg::op_neg:
			begin
				x        = 8'h00;
				y        = ~acc;
				cin      = 1'b1;
				sub_mode = 1'b1;
			end
			default:
				cin = 1'b0;
		endcase
	end

	// single 9 bit adder, nibble sum only for the half carry
	assign sum9 = {1'b0, x} + {1'b0, y} + {8'd0, cin};
	assign nib5 = {1'b0, x[3:0]} + {1'b0, y[3:0]} + {4'd0, cin};

	assign arith_result = sum9[7:0];
	// carry turns into borrow when subtracting
	assign carry_out = sum9[8] ^ sub_mode;
	assign half_out  = nib5[4] ^ sub_mode;
	// like signs in, other sign out
	assign ovf_out   = (x[7] == y[7]) && (sum9[7] != x[7]);

endmodule

`default_nettype wire

// ==== src/alu_logic_mux.sv ====
`default_nettype none

module alu_logic_mux (
	input  var z80_alu_pkg::alu_op_e op,
	input  var z80_alu_pkg::byte_t   acc,
	input  var z80_alu_pkg::byte_t   data_bus,
	input  var z80_alu_pkg::byte_t   arith_result,
	output z80_alu_pkg::byte_t       op_result,
	output logic                     parity_even
);

	z80_alu_pkg::byte_t logic_val;
	logic is_logic;

	//////////////////////////////////////////////////////////////////////
	// bitwise ops
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		logic_val = '0;
		is_logic  = 1'b1;
		case (op)
			z80_alu_pkg::op_and:
				logic_val = acc & data_bus;
			z80_alu_pkg::op_or:
				logic_val = acc | data_bus;
			z80_alu_pkg::op_xor:
				logic_val = acc ^ data_bus;
			// complement of the accumulator
			z80_alu_pkg::op_cpl:
				logic_val = ~acc;
			default:
				is_logic = 1'b0;
		endcase
	end

	// adder output for everything else
	assign op_result = is_logic ? logic_val : arith_result;

	// xnor reduce, high for an even count of ones
	assign parity_even = ~^op_result;

endmodule

`default_nettype wire

// ==== src/alu_flags.sv ====
`default_nettype none

module alu_flags (
	input  wire logic                clk,
	input  wire logic                rst,
	input  var z80_alu_pkg::alu_op_e op,
	input  var z80_alu_pkg::byte_t   op_result,
	input  wire logic                parity_even,
	input  wire logic                carry_out,
	input  wire logic                half_out,
	input  wire logic                ovf_out,
	output z80_alu_pkg::flags_t      flags,
	output logic                     carry_in
);

	z80_alu_pkg::flags_t flags_nxt;
	logic res_zero;

	assign res_zero = (op_result == 8'h00);

	//////////////////////////////////////////////////////////////////////
	// per opcode flag merge
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// unlisted flags keep their value
		flags_nxt = flags;
		case (op)
			z80_alu_pkg::op_add, z80_alu_pkg::op_adc,
			z80_alu_pkg::op_sub, z80_alu_pkg::op_sbc,
			z80_alu_pkg::op_cp, z80_alu_pkg::op_neg:
			begin
				flags_nxt[z80_alu_pkg::FLAG_S]  = op_result[7];
				flags_nxt[z80_alu_pkg::FLAG_Z]  = res_zero;
				flags_nxt[z80_alu_pkg::FLAG_H]  = half_out;
				flags_nxt[z80_alu_pkg::FLAG_PV] = ovf_out;
				flags_nxt[z80_alu_pkg::FLAG_N]  = (op != z80_alu_pkg::op_add) &&
					(op != z80_alu_pkg::op_adc);
				flags_nxt[z80_alu_pkg::FLAG_C]  = carry_out;
			end
			// carry left alone
			z80_alu_pkg::op_inc, z80_alu_pkg::op_dec:
			begin
				flags_nxt[z80_alu_pkg::FLAG_S]  = op_result[7];
				flags_nxt[z80_alu_pkg::FLAG_Z]  = res_zero;
				flags_nxt[z80_alu_pkg::FLAG_H]  = half_out;
				flags_nxt[z80_alu_pkg::FLAG_PV] = ovf_out;
				flags_nxt[z80_alu_pkg::FLAG_N]  = (op == z80_alu_pkg::op_dec);
			end
			// pv carries parity here
			z80_alu_pkg::op_and, z80_alu_pkg::op_or, z80_alu_pkg::op_xor:
			begin
				flags_nxt[z80_alu_pkg::FLAG_S]  = op_result[7];
				flags_nxt[z80_alu_pkg::FLAG_Z]  = res_zero;
				flags_nxt[z80_alu_pkg::FLAG_H]  = (op == z80_alu_pkg::op_and);
				flags_nxt[z80_alu_pkg::FLAG_PV] = parity_even;
				flags_nxt[z80_alu_pkg::FLAG_N]  = 1'b0;
				flags_nxt[z80_alu_pkg::FLAG_C]  = 1'b0;
			end
			z80_alu_pkg::op_cpl:
			begin
				flags_nxt[z80_alu_pkg::FLAG_H] = 1'b1;
				flags_nxt[z80_alu_pkg::FLAG_N] = 1'b1;
			end
			// old carry moves into h
			z80_alu_pkg::op_ccf:
			begin
				flags_nxt[z80_alu_pkg::FLAG_H] = flags[z80_alu_pkg::FLAG_C];
				flags_nxt[z80_alu_pkg::FLAG_C] = ~flags[z80_alu_pkg::FLAG_C];
				flags_nxt[z80_alu_pkg::FLAG_N] = 1'b0;
			end
			z80_alu_pkg::op_scf:
			begin
				flags_nxt[z80_alu_pkg::FLAG_C] = 1'b1;
				flags_nxt[z80_alu_pkg::FLAG_H] = 1'b0;
				flags_nxt[z80_alu_pkg::FLAG_N] = 1'b0;
			end
			default:
				flags_nxt = flags;
		endcase
		// bits 3 and 5 tied low
		flags_nxt[3] = 1'b0;
		flags_nxt[5] = 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			flags <= '0;
		else
			flags <= flags_nxt;
	end

	// stored carry back to the adder
	assign carry_in = flags[z80_alu_pkg::FLAG_C];

endmodule

`default_nettype wire

// ==== src/alu_writeback.sv ====
`default_nettype none

module alu_writeback #(
	parameter int NUM_REGS = 7
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  var z80_alu_pkg::alu_op_e         op,
	input  var z80_alu_pkg::byte_t           op_result,
	input  wire logic [NUM_REGS-1:0]         r_sel,
	output z80_alu_pkg::byte_t               result,
	output logic [NUM_REGS-1:0]              rf_ld,
	output logic                             f_ld,
	output logic [$clog2(NUM_REGS)-1:0]      rf_re
);

	localparam int IDX_W = $clog2(NUM_REGS);

	logic [NUM_REGS-1:0] ld_nxt;
	logic [IDX_W-1:0] re_nxt;
	logic [IDX_W-1:0] sel_idx;
	logic f_ld_nxt;

	// lowest set bit wins, scan from the top down
	always_comb
	begin
		sel_idx = '0;
		for (int i = NUM_REGS - 1; i >= 0; i--)
			if (r_sel[i])
				sel_idx = IDX_W'(i);
	end

	//////////////////////////////////////////////////////////////////////
	// load strobes by opcode
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		ld_nxt   = '0;
		re_nxt   = '0;
		f_ld_nxt = 1'b1;
		case (op)
			// accumulator only
			z80_alu_pkg::op_add, z80_alu_pkg::op_adc,
			z80_alu_pkg::op_sub, z80_alu_pkg::op_sbc,
			z80_alu_pkg::op_and, z80_alu_pkg::op_or, z80_alu_pkg::op_xor,
			z80_alu_pkg::op_cpl, z80_alu_pkg::op_neg:
				ld_nxt[0] = 1'b1;
			// target register from r_sel
			z80_alu_pkg::op_inc, z80_alu_pkg::op_dec:
			begin
				ld_nxt = r_sel;
				re_nxt = sel_idx;
			end
			// flags only
			z80_alu_pkg::op_cp, z80_alu_pkg::op_ccf, z80_alu_pkg::op_scf:
				ld_nxt = '0;
			// nop and code 14
			default:
				f_ld_nxt = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result <= '0;
			rf_ld  <= '0;
			f_ld   <= 1'b0;
			rf_re  <= '0;
		end
		else
		begin
			// result holds unless a register loads
			if (|ld_nxt)
				result <= op_result;
			rf_ld <= ld_nxt;
			f_ld  <= f_ld_nxt;
			rf_re <= re_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== src/z80_alu.sv ====
`default_nettype none

module z80_alu #(
	// general registers, register 0 is the accumulator
	parameter int NUM_REGS = 7
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  var z80_alu_pkg::alu_op_e         sel,
	input  var z80_alu_pkg::byte_t           acc,
	input  var z80_alu_pkg::byte_t           data_bus,
	input  wire logic [NUM_REGS-1:0]         r_sel,
	output z80_alu_pkg::byte_t               result,
	output z80_alu_pkg::flags_t              flags,
	output logic [NUM_REGS-1:0]              rf_ld,
	output logic                             f_ld,
	output logic [$clog2(NUM_REGS)-1:0]      rf_re
);

	// adder outputs
	z80_alu_pkg::byte_t arith_result;
	logic carry_out;
	logic half_out;
	logic ovf_out;
	// selected result and its parity
	z80_alu_pkg::byte_t op_result;
	logic parity_even;
	// stored carry fed back
	logic carry_in;

	//////////////////////////////////////////////////////////////////////
	// datapath, one register stage at the end
	//////////////////////////////////////////////////////////////////////
	alu_arith i_arith (
		.op           (sel),
		.acc          (acc),
		.data_bus     (data_bus),
		.carry_in     (carry_in),
		.arith_result (arith_result),
		.carry_out    (carry_out),
		.half_out     (half_out),
		.ovf_out      (ovf_out)
	);

	alu_logic_mux i_logic_mux (
		.op           (sel),
		.acc          (acc),
		.data_bus     (data_bus),
		.arith_result (arith_result),
		.op_result    (op_result),
		.parity_even  (parity_even)
	);

	alu_flags i_flags (
		.clk         (clk),
		.rst         (rst),
		.op          (sel),
		.op_result   (op_result),
		.parity_even (parity_even),
		.carry_out   (carry_out),
		.half_out    (half_out),
		.ovf_out     (ovf_out),
		.flags       (flags),
		.carry_in    (carry_in)
	);

	alu_writeback #(
		.NUM_REGS (NUM_REGS)
	) i_writeback (
		.clk       (clk),
		.rst       (rst),
		.op        (sel),
		.op_result (op_result),
		.r_sel     (r_sel),
		.result    (result),
		.rf_ld     (rf_ld),
		.f_ld      (f_ld),
		.rf_re     (rf_re)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS  = 4,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	// free running clock
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	// reset held over the first rising edges, released on a falling edge
	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/z80_alu_chk.sv ====
`default_nettype none

module z80_alu_chk #(
	parameter int NUM_REGS = 7
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic [NUM_REGS-1:0] r_sel,
	input  var z80_alu_pkg::byte_t   result,
	input  var z80_alu_pkg::flags_t  flags,
	input  wire logic [NUM_REGS-1:0] rf_ld,
	input  wire logic                f_ld
);
	timeunit 1ns;
	timeprecision 1ps;

	// failures seen here, summed into the testbench error count
	int fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// output properties
	//////////////////////////////////////////////////////////////////////

	// strobes and result cleared one cycle after reset
	clear_after_rst: assert property (@(posedge clk)
		rst |=> (rf_ld == '0 && !f_ld && result == 8'h00))
		else
		begin
			$error("rf_ld, f_ld or result not cleared after reset");
			fail_cnt++;
		end

	// at most one register strobe for a one-hot select, one cycle later
	ld_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(r_sel) |=> $onehot0(rf_ld))
		else
		begin
			$error("rf_ld has more than one bit set");
			fail_cnt++;
		end

	// undocumented bits stay low
	flag_bits_low: assert property (@(posedge clk) disable iff (rst)
		!flags[3] && !flags[5])
		else
		begin
			$error("flag bit 3 or 5 is set");
			fail_cnt++;
		end

	// no flag load, no flag change
	flags_hold: assert property (@(posedge clk) disable iff (rst)
		(!f_ld && !$past(rst)) |-> $stable(flags))
		else
		begin
			$error("flags changed while f_ld was low");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// ==== sim/tb_z80_alu.sv ====
`default_nettype none

module tb_z80_alu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_REGS = 7;
	localparam int RE_W     = $clog2(NUM_REGS);
	localparam int CLK_NS   = 4;
	// operand counts of the randomized loops
	localparam int N_PAIRS = 40;
	localparam int N_LOGIC = 10;
	localparam int N_NEG   = 10;
	// operations issued, test by test
	localparam int TOTAL_OPS = 2 + (4 + 3 * N_PAIRS) + 23 + 5 * N_LOGIC
		+ (1 + 2 * NUM_REGS + 4) + (2 + N_NEG);
	localparam int WATCHDOG_NS = TOTAL_OPS * CLK_NS * 4 + 200;

	logic clk;
	logic rst;
	z80_alu_pkg::alu_op_e sel;
	z80_alu_pkg::byte_t acc;
	z80_alu_pkg::byte_t data_bus;
	logic [NUM_REGS-1:0] r_sel;
	z80_alu_pkg::byte_t result;
	z80_alu_pkg::flags_t flags;
	logic [NUM_REGS-1:0] rf_ld;
	logic f_ld;
	logic [RE_W-1:0] rf_re;

	// reference model state
	z80_alu_pkg::flags_t m_flags;
	z80_alu_pkg::byte_t m_result;
	logic [NUM_REGS-1:0] m_ld;
	logic m_f_ld;
	logic [RE_W-1:0] m_re;

	int n_err;
	int n_checks;
	int n_tests;
	logic [31:0] lcg_state;

	tb_clk_gen #(
		.PERIOD_NS  (CLK_NS),
		.RST_CYCLES (2)
	) i_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	z80_alu #(
		.NUM_REGS (NUM_REGS)
	) i_z80_alu (
		.clk      (clk),
		.rst      (rst),
		.sel      (sel),
		.acc      (acc),
		.data_bus (data_bus),
		.r_sel    (r_sel),
		.result   (result),
		.flags    (flags),
		.rf_ld    (rf_ld),
		.f_ld     (f_ld),
		.rf_re    (rf_re)
	);

	bind z80_alu z80_alu_chk #(
		.NUM_REGS (NUM_REGS)
	) i_chk (
		.clk    (clk),
		.rst    (rst),
		.r_sel  (r_sel),
		.result (result),
		.flags  (flags),
		.rf_ld  (rf_ld),
		.f_ld   (f_ld)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// lcg, middle bits taken as the byte
	function automatic z80_alu_pkg::byte_t next_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic logic even_parity(input z80_alu_pkg::byte_t v);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones += int'(v[i]);
		return (ones % 2) == 0;
	endfunction

	// index of lowest set bit, 0 when none
	function automatic logic [RE_W-1:0] lowest_index(input logic [NUM_REGS-1:0] v);
		int idx;
		idx = -1;
		for (int i = 0; i < NUM_REGS; i++)
			if (v[i] && idx < 0)
				idx = i;
		if (idx < 0)
			idx = 0;
		return idx[RE_W-1:0];
	endfunction

	task automatic check_byte(input string name, input z80_alu_pkg::byte_t got,
		input z80_alu_pkg::byte_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_err++;
			$display("FAIL t=%0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_flags(input z80_alu_pkg::flags_t got, input z80_alu_pkg::flags_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_err++;
			$display("FAIL t=%0t flags got %08b expected %08b", $time, got, exp);
		end
	endtask

	task automatic check_ld(input logic [NUM_REGS-1:0] got_ld, input logic got_f,
		input logic [NUM_REGS-1:0] exp_ld, input logic exp_f);
		n_checks++;
		if (got_ld !== exp_ld)
		begin
			n_err++;
			$display("FAIL t=%0t rf_ld got %b expected %b", $time, got_ld, exp_ld);
		end
		if (got_f !== exp_f)
		begin
			n_err++;
			$display("FAIL t=%0t f_ld got %b expected %b", $time, got_f, exp_f);
		end
	endtask

	task automatic check_re(input logic [RE_W-1:0] got, input logic [RE_W-1:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_err++;
			$display("FAIL t=%0t rf_re got %0d expected %0d", $time, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model, one step per issued opcode
	//////////////////////////////////////////////////////////////////////
	task automatic model_step(input z80_alu_pkg::alu_op_e op, input z80_alu_pkg::byte_t a,
		input z80_alu_pkg::byte_t b, input logic [NUM_REGS-1:0] rs);
		int wide;
		int nib;
		int cin;
		logic set_sz;
		z80_alu_pkg::byte_t r;
		z80_alu_pkg::flags_t f;
		logic [NUM_REGS-1:0] ld;
		f = m_flags;
		r = 8'h00;
		ld = '0;
		cin = 0;
		set_sz = 1'b1;
		case (op)
			z80_alu_pkg::op_add, z80_alu_pkg::op_adc:
			begin
				if (op == z80_alu_pkg::op_adc)
					cin = int'(m_flags[z80_alu_pkg::FLAG_C]);
				wide = int'(a) + int'(b) + cin;
				nib = int'(a[3:0]) + int'(b[3:0]) + cin;
				r = wide[7:0];
				f[z80_alu_pkg::FLAG_C] = (wide > 255);
				f[z80_alu_pkg::FLAG_H] = (nib > 15);
				f[z80_alu_pkg::FLAG_PV] = (a[7] == b[7]) && (r[7] != a[7]);
				f[z80_alu_pkg::FLAG_N] = 1'b0;
				ld[0] = 1'b1;
			end
			// borrows show up as negative differences
			z80_alu_pkg::op_sub, z80_alu_pkg::op_sbc, z80_alu_pkg::op_cp:
			begin
				if (op == z80_alu_pkg::op_sbc)
					cin = int'(m_flags[z80_alu_pkg::FLAG_C]);
				wide = int'(a) - int'(b) - cin;
				nib = int'(a[3:0]) - int'(b[3:0]) - cin;
				r = wide[7:0];
				f[z80_alu_pkg::FLAG_C] = (wide < 0);
				f[z80_alu_pkg::FLAG_H] = (nib < 0);
				f[z80_alu_pkg::FLAG_PV] = (a[7] != b[7]) && (r[7] != a[7]);
				f[z80_alu_pkg::FLAG_N] = 1'b1;
				ld[0] = (op != z80_alu_pkg::op_cp);
			end
			z80_alu_pkg::op_inc:
			begin
				r = b + 8'd1;
				f[z80_alu_pkg::FLAG_H] = (b[3:0] == 4'hf);
				f[z80_alu_pkg::FLAG_PV] = (b == 8'h7f);
				f[z80_alu_pkg::FLAG_N] = 1'b0;
				ld = rs;
			end
			z80_alu_pkg::op_dec:
			begin
				r = b - 8'd1;
				f[z80_alu_pkg::FLAG_H] = (b[3:0] == 4'h0);
				f[z80_alu_pkg::FLAG_PV] = (b == 8'h80);
				f[z80_alu_pkg::FLAG_N] = 1'b1;
				ld = rs;
			end
			z80_alu_pkg::op_neg:
			begin
				r = 8'h00 - a;
				f[z80_alu_pkg::FLAG_C] = (a != 8'h00);
				f[z80_alu_pkg::FLAG_H] = (a[3:0] != 4'h0);
				f[z80_alu_pkg::FLAG_PV] = (a == 8'h80);
				f[z80_alu_pkg::FLAG_N] = 1'b1;
				ld[0] = 1'b1;
			end
			z80_alu_pkg::op_and, z80_alu_pkg::op_or, z80_alu_pkg::op_xor:
			begin
				if (op == z80_alu_pkg::op_and)
					r = a & b;
				else if (op == z80_alu_pkg::op_or)
					r = a | b;
				else
					r = a ^ b;
				f[z80_alu_pkg::FLAG_C] = 1'b0;
				f[z80_alu_pkg::FLAG_N] = 1'b0;
				f[z80_alu_pkg::FLAG_H] = (op == z80_alu_pkg::op_and);
				f[z80_alu_pkg::FLAG_PV] = even_parity(r);
				ld[0] = 1'b1;
			end
			// s, z, pv and c kept
			z80_alu_pkg::op_cpl:
			begin
				r = ~a;
				f[z80_alu_pkg::FLAG_H] = 1'b1;
				f[z80_alu_pkg::FLAG_N] = 1'b1;
				ld[0] = 1'b1;
				set_sz = 1'b0;
			end
			z80_alu_pkg::op_ccf:
			begin
				f[z80_alu_pkg::FLAG_H] = m_flags[z80_alu_pkg::FLAG_C];
				f[z80_alu_pkg::FLAG_C] = ~m_flags[z80_alu_pkg::FLAG_C];
				f[z80_alu_pkg::FLAG_N] = 1'b0;
				set_sz = 1'b0;
			end
			z80_alu_pkg::op_scf:
			begin
				f[z80_alu_pkg::FLAG_C] = 1'b1;
				f[z80_alu_pkg::FLAG_H] = 1'b0;
				f[z80_alu_pkg::FLAG_N] = 1'b0;
				set_sz = 1'b0;
			end
			default:
				set_sz = 1'b0;
		endcase
		if (set_sz)
		begin
			f[z80_alu_pkg::FLAG_S] = r[7];
			f[z80_alu_pkg::FLAG_Z] = (r == 8'h00);
		end
		m_flags = f;
		m_ld = ld;
		m_f_ld = (op != z80_alu_pkg::op_nop);
		if (op == z80_alu_pkg::op_inc || op == z80_alu_pkg::op_dec)
			m_re = lowest_index(rs);
		else
			m_re = '0;
		// result register only loads with a strobe
		if (ld != '0)
			m_result = r;
	endtask

	// called on a falling edge, returns on the next one after checking
	task automatic run_op(input z80_alu_pkg::alu_op_e op, input z80_alu_pkg::byte_t a,
		input z80_alu_pkg::byte_t b, input logic [NUM_REGS-1:0] rs);
		sel = op;
		acc = a;
		data_bus = b;
		r_sel = rs;
		model_step(op, a, b, rs);
		@(negedge clk);
		check_byte("result", result, m_result);
		check_flags(flags, m_flags);
		check_ld(rf_ld, f_ld, m_ld, m_f_ld);
		check_re(rf_re, m_re);
	endtask

	task automatic finish_test(input string name, input int err_start);
		n_tests++;
		$display("test %-10s %s, %0d errors", name,
			(n_err == err_start) ? "ok" : "failed", n_err - err_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic reset_values();
		int err_start;
		err_start = n_err;
		wait (rst === 1'b0);
		check_byte("result", result, 8'h00);
		check_flags(flags, 8'h00);
		check_ld(rf_ld, f_ld, '0, 1'b0);
		check_re(rf_re, '0);
		run_op(z80_alu_pkg::op_nop, 8'h00, 8'h00, '0);
		run_op(z80_alu_pkg::op_nop, 8'h00, 8'h00, '0);
		finish_test("reset", err_start);
	endtask

	task automatic add_sub_cases();
		int err_start;
		z80_alu_pkg::byte_t a;
		z80_alu_pkg::byte_t b;
		err_start = n_err;
		// overflow, carry, borrow and zero corners
		run_op(z80_alu_pkg::op_add, 8'h7f, 8'h01, '0);
		run_op(z80_alu_pkg::op_add, 8'hff, 8'h01, '0);
		run_op(z80_alu_pkg::op_sub, 8'h00, 8'h01, '0);
		run_op(z80_alu_pkg::op_sub, 8'h80, 8'h01, '0);
		for (int i = 0; i < N_PAIRS; i++)
		begin
			a = next_byte();
			b = next_byte();
			run_op(z80_alu_pkg::op_add, a, b, '0);
			run_op(z80_alu_pkg::op_sub, a, b, '0);
			run_op(z80_alu_pkg::op_cp, a, b, '0);
		end
		finish_test("add_sub", err_start);
	endtask

	task automatic carry_chains();
		int err_start;
		z80_alu_pkg::byte_t a;
		z80_alu_pkg::byte_t b;
		err_start = n_err;
		// carry in wraps ff to 00, then half carry, then borrow in
		run_op(z80_alu_pkg::op_scf, 8'h00, 8'h00, '0);
		run_op(z80_alu_pkg::op_adc, 8'hff, 8'h00, '0);
		run_op(z80_alu_pkg::op_adc, 8'h0f, 8'h00, '0);
		run_op(z80_alu_pkg::op_ccf, 8'h00, 8'h00, '0);
		run_op(z80_alu_pkg::op_sbc, 8'h10, 8'h0f, '0);
		for (int i = 0; i < 6; i++)
		begin
			a = next_byte();
			b = next_byte();
			run_op(z80_alu_pkg::op_adc, a, b, '0);
			a = next_byte();
			b = next_byte();
			run_op(z80_alu_pkg::op_sbc, a, b, '0);
			if (i % 2 == 1)
				run_op(z80_alu_pkg::op_ccf, a, b, '0);
			else
				run_op(z80_alu_pkg::op_scf, a, b, '0);
		end
		finish_test("carry", err_start);
	endtask

	task automatic logic_ops();
		int err_start;
		z80_alu_pkg::byte_t a;
		z80_alu_pkg::byte_t b;
		err_start = n_err;
		for (int i = 0; i < N_LOGIC; i++)
		begin
			a = next_byte();
			b = next_byte();
			run_op(z80_alu_pkg::op_and, a, b, '0);
			run_op(z80_alu_pkg::op_or, a, b, '0);
			run_op(z80_alu_pkg::op_xor, a, b, '0);
			// carry set so cpl must keep it
			run_op(z80_alu_pkg::op_scf, a, b, '0);
			run_op(z80_alu_pkg::op_cpl, a, b, '0);
		end
		finish_test("logic", err_start);
	endtask

	task automatic inc_dec_regs();
		int err_start;
		z80_alu_pkg::byte_t a;
		z80_alu_pkg::byte_t b;
		logic [NUM_REGS-1:0] rs;
		err_start = n_err;
		rs = '0;
		run_op(z80_alu_pkg::op_scf, 8'h00, 8'h00, '0);
		for (int i = 0; i < NUM_REGS; i++)
		begin
			rs = '0;
			rs[i] = 1'b1;
			a = next_byte();
			b = next_byte();
			run_op(z80_alu_pkg::op_inc, a, b, rs);
			b = next_byte();
			run_op(z80_alu_pkg::op_dec, a, b, rs);
		end
		// signed overflow and wrap to zero
		run_op(z80_alu_pkg::op_inc, 8'h00, 8'h7f, rs);
		run_op(z80_alu_pkg::op_dec, 8'h00, 8'h80, rs);
		run_op(z80_alu_pkg::op_inc, 8'h00, 8'hff, rs);
		run_op(z80_alu_pkg::op_dec, 8'h00, 8'h00, rs);
		finish_test("inc_dec", err_start);
	endtask

	task automatic negate_cases();
		int err_start;
		err_start = n_err;
		run_op(z80_alu_pkg::op_neg, 8'h00, 8'h00, '0);
		run_op(z80_alu_pkg::op_neg, 8'h80, 8'h00, '0);
		for (int i = 0; i < N_NEG; i++)
			run_op(z80_alu_pkg::op_neg, next_byte(), 8'h00, '0);
		finish_test("neg", err_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequencing and watchdog
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		sel = z80_alu_pkg::op_nop;
		acc = 8'h00;
		data_bus = 8'h00;
		r_sel = '0;
		m_flags = '0;
		m_result = 8'h00;
		m_ld = '0;
		m_f_ld = 1'b0;
		m_re = '0;
		n_err = 0;
		n_checks = 0;
		n_tests = 0;
		lcg_state = 32'd14;
		reset_values();
		add_sub_cases();
		carry_chains();
		logic_ops();
		inc_dec_regs();
		negate_cases();
		sel = z80_alu_pkg::op_nop;
		@(negedge clk);
		// failures seen by the bound checker
		n_err += i_z80_alu.i_chk.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_err);
		if (n_err == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== z80_alu.f ====
src/z80_alu_pkg.sv
src/alu_arith.sv
src/alu_logic_mux.sv
src/alu_flags.sv
src/alu_writeback.sv
src/z80_alu.sv
sim/tb_clk_gen.sv
sim/z80_alu_chk.sv
sim/tb_z80_alu.sv

// ==== Bender.yml ====
package:
  name: z80_alu

sources:
  - src/z80_alu_pkg.sv
  - src/alu_arith.sv
  - src/alu_logic_mux.sv
  - src/alu_flags.sv
  - src/alu_writeback.sv
  - src/z80_alu.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/z80_alu_chk.sv
      - sim/tb_z80_alu.sv
